// File: flist.f
src/fetch_pkg.sv
src/branch_predictor.sv
src/instr_mem.sv
src/fetch_stage.sv
src/if_id_reg.sv
src/fetch_top.sv
testbench/tb_fetch_asserts.sv
testbench/tb_fetch_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_fetch_top -f flist.f \
  -o sim_fetch > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_fetch > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "FAIL"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "FAIL, run did not complete"; exit 1; }
echo "PASS" && exit 0

// File: src/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [fetch_pkg::BP_IDX_W-1:0] lookup_idx,  // PC[3:0] of the fetch
  input  logic                          upd_valid,    // Resolve pulse from decode
  input  logic [fetch_pkg::BP_IDX_W-1:0] upd_idx,     // PC[3:0] of the resolved branch
  input  logic                          upd_taken,    // Actual outcome
  input  logic [fetch_pkg::ADDR_W-1:0]   upd_target,  // Actual target
  output logic                          pred_taken,
  output logic [fetch_pkg::ADDR_W-1:0]   pred_target
);
  import fetch_pkg::*;

  bht_state_e        bht        [BP_ENTRIES];  // Branch history table
  logic [ADDR_W-1:0] btb_target [BP_ENTRIES];  // Branch target buffer, no tags
  logic [BP_ENTRIES-1:0] btb_valid;            // BTB entry holds a target

  // One saturating step toward the outcome
  function automatic bht_state_e bht_step(input bht_state_e cur, input logic taken);
    bht_state_e nxt;
    nxt = cur;
    case (cur)
      strong_not_taken: nxt = taken ? weak_not_taken : strong_not_taken;
      weak_not_taken:   nxt = taken ? weak_taken     : strong_not_taken;
      weak_taken:       nxt = taken ? strong_taken   : weak_not_taken;
      strong_taken:     nxt = taken ? strong_taken   : weak_taken;
      default:          nxt = weak_not_taken;
    endcase
    return nxt;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Lookup, purely combinational
  ////////////////////////////////////////////////////////////////////////////
  logic ctr_taken;

  // Taken states only
  assign ctr_taken   = (bht[lookup_idx] == weak_taken) || (bht[lookup_idx] == strong_taken);
  // No target cached means fall through to PC+2
  assign pred_taken  = ctr_taken && btb_valid[lookup_idx];
  assign pred_target = btb_target[lookup_idx];

  ////////////////////////////////////////////////////////////////////////////
  // Resolve-time update
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < BP_ENTRIES; i++) begin
        bht[i] <= weak_not_taken;
      end
      btb_valid <= '0;                         // All targets unknown
    end else if (upd_valid) begin
      bht[upd_idx] <= bht_step(bht[upd_idx], upd_taken);
      if (upd_taken) begin
        btb_valid[upd_idx] <= 1'b1;            // Taken outcome caches its target
      end
    end
  end

  // Target payload, qualified by btb_valid
  always_ff @(posedge clk) begin
    if (upd_valid && upd_taken) begin
      btb_target[upd_idx] <= upd_target;
    end
  end

endmodule

// File: src/fetch_pkg.sv
package fetch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int ADDR_W  = 16;             // Byte address of the PC
  localparam int INSTR_W = 16;             // One instruction word

  ////////////////////////////////////////////////////////////////////////////
  // Predictor and memory sizes
  ////////////////////////////////////////////////////////////////////////////
  localparam int BP_IDX_W   = 4;                 // Indexed by PC[3:0]
  localparam int BP_ENTRIES = 1 << BP_IDX_W;     // BHT and BTB depth
  localparam int IMEM_AW    = 8;                 // Word address, PC[8:1]
  localparam int IMEM_DEPTH = 1 << IMEM_AW;      // 256 instruction words

  // Where fetch starts after reset
  localparam logic [ADDR_W-1:0] RESET_PC = '0;

  // 2-bit saturating counter, MSB set means predict taken
  typedef enum logic [1:0] {
    strong_not_taken = 2'b00,
    weak_not_taken   = 2'b01,  // Reset state
    weak_taken       = 2'b10,
    strong_taken     = 2'b11
  } bht_state_e;

endpackage

// File: src/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          advance,         // PC write enable from IF/ID
  input  logic                          res_valid,       // Resolve pulse
  input  logic [fetch_pkg::ADDR_W-1:0]  res_pc,
  input  logic                          res_taken,
  input  logic [fetch_pkg::ADDR_W-1:0]  res_target,
  input  logic                          res_mispredict,
  input  logic                          load_en,
  input  logic [fetch_pkg::IMEM_AW-1:0] load_addr,
  input  logic [fetch_pkg::INSTR_W-1:0] load_data,
  output logic [fetch_pkg::ADDR_W-1:0]  pc_curr,
  output logic [fetch_pkg::INSTR_W-1:0] instr,
  output logic                          pred_taken
);
  import fetch_pkg::*;

  logic [ADDR_W-1:0] pc_plus2;      // Sequential address
  logic [ADDR_W-1:0] pred_target;   // From the BTB
  logic [ADDR_W-1:0] pc_pred;       // Predicted next PC
  logic [ADDR_W-1:0] redirect_pc;   // Correct path after a mispredict
  logic [ADDR_W-1:0] pc_next;
  logic              redirect;
  logic              pc_we;

  ////////////////////////////////////////////////////////////////////////////
  // Next PC selection
  ////////////////////////////////////////////////////////////////////////////
  assign pc_plus2    = pc_curr + ADDR_W'(2);                      // 2 bytes per instruction
  assign pc_pred     = pred_taken ? pred_target : pc_plus2;
  assign redirect    = res_valid && res_mispredict;
  assign redirect_pc = res_taken ? res_target : res_pc + ADDR_W'(2);
  assign pc_next     = redirect ? redirect_pc : pc_pred;           // Redirect wins
  assign pc_we       = advance || redirect;                        // Redirect ignores stall

  // PC register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_curr <= RESET_PC;
    end else if (pc_we) begin
      pc_curr <= pc_next;
    end
  end

  branch_predictor branch_predictor_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .lookup_idx  (pc_curr[BP_IDX_W-1:0]),
    .upd_valid   (res_valid),
    .upd_idx     (res_pc[BP_IDX_W-1:0]),
    .upd_taken   (res_taken),
    .upd_target  (res_target),
    .pred_taken  (pred_taken),
    .pred_target (pred_target)
  );

  // Byte PC to word address
  instr_mem instr_mem_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_addr (pc_curr[IMEM_AW:1]),
    .rd_data (instr),
    .wr_en   (load_en),
    .wr_addr (load_addr),
    .wr_data (load_data)
  );

endmodule

// File: src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
  input  logic                          clk,
  input  logic                          rst_n,
  // Program load
  input  logic                          load_en,
  input  logic [fetch_pkg::IMEM_AW-1:0] load_addr,
  input  logic [fetch_pkg::INSTR_W-1:0] load_data,
  // Decode handshake
  output logic                          out_valid,
  input  logic                          out_ready,
  output logic [fetch_pkg::ADDR_W-1:0]  out_pc,
  output logic [fetch_pkg::INSTR_W-1:0] out_instr,
  output logic                          out_pred_taken,
  // Branch resolve from decode
  input  logic                          res_valid,
  input  logic [fetch_pkg::ADDR_W-1:0]  res_pc,
  input  logic                          res_taken,
  input  logic [fetch_pkg::ADDR_W-1:0]  res_target,
  input  logic                          res_mispredict
);
  import fetch_pkg::*;

  logic [ADDR_W-1:0]  pc_curr;     // Fetch PC
  logic [INSTR_W-1:0] instr;       // Word at pc_curr
  logic               pred_taken;
  logic               advance;     // IF/ID can take a new item

  fetch_stage fetch_stage_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .advance        (advance),
    .res_valid      (res_valid),
    .res_pc         (res_pc),
    .res_taken      (res_taken),
    .res_target     (res_target),
    .res_mispredict (res_mispredict),
    .load_en        (load_en),
    .load_addr      (load_addr),
    .load_data      (load_data),
    .pc_curr        (pc_curr),
    .instr          (instr),
    .pred_taken     (pred_taken)
  );

  if_id_reg if_id_reg_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_pc          (pc_curr),
    .in_instr       (instr),
    .in_pred_taken  (pred_taken),
    .flush          (res_mispredict),  // Resolve pulses are single cycle
    .advance        (advance),
    .out_valid      (out_valid),
    .out_pc         (out_pc),
    .out_instr      (out_instr),
    .out_pred_taken (out_pred_taken),
    .out_ready      (out_ready)
  );

endmodule

// File: src/if_id_reg.sv
`timescale 1ns/1ps

module if_id_reg (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [fetch_pkg::ADDR_W-1:0]  in_pc,
  input  logic [fetch_pkg::INSTR_W-1:0] in_instr,
  input  logic                          in_pred_taken,
  input  logic                          flush,           // Mispredict from decode
  output logic                          advance,         // Back to the PC register
  output logic                          out_valid,
  output logic [fetch_pkg::ADDR_W-1:0]  out_pc,
  output logic [fetch_pkg::INSTR_W-1:0] out_instr,
  output logic                          out_pred_taken,
  input  logic                          out_ready
);
  import fetch_pkg::*;

  // Empty, or the held item leaves this edge
  assign advance = !out_valid || out_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Valid bit
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (flush) begin
      out_valid <= 1'b0;                 // Wrong-path item dropped
    end else if (advance) begin
      out_valid <= 1'b1;                 // Fetch always has an item
    end
  end

  // Payload, frozen under back-pressure
  always_ff @(posedge clk) begin
    if (advance) begin
      out_pc         <= in_pc;
      out_instr      <= in_instr;
      out_pred_taken <= in_pred_taken;
    end
  end

endmodule

// File: src/instr_mem.sv
`timescale 1ns/1ps

module instr_mem (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [fetch_pkg::IMEM_AW-1:0] rd_addr,   // Word address from PC[8:1]
  output logic [fetch_pkg::INSTR_W-1:0] rd_data,
  input  logic                          wr_en,     // Program load strobe
  input  logic [fetch_pkg::IMEM_AW-1:0] wr_addr,
  input  logic [fetch_pkg::INSTR_W-1:0] wr_data
);
  import fetch_pkg::*;

  logic [INSTR_W-1:0] mem [IMEM_DEPTH];  // Program storage

  // Asynchronous read, instruction valid in the same cycle as the PC
  assign rd_data = mem[rd_addr];

  // Program load port
  always_ff @(posedge clk) begin
    if (wr_en && rst_n) begin              // Loads ignored while in reset
      mem[wr_addr] <= wr_data;
    end
  end

endmodule

// File: testbench/fetch_testdata.hex
// Words 0-7 program, 8 ready pattern (bit 0 first, 0 stalls), 9 mispredict pc,
// 10 mispredict target, 11 trained pc, 12 trained target, 13 restart resolve pc
1A01
2B02
3C03
4D04
5E05
6F06
7007
8108
B6D9
0006
0080
0024
0060
001C

// File: testbench/tb_fetch_asserts.sv
`timescale 1ns/1ps

module tb_fetch_asserts (
  input logic                          clk,
  input logic                          rst_n,
  input logic                          out_valid,
  input logic                          out_ready,
  input logic [fetch_pkg::ADDR_W-1:0]  out_pc,
  input logic [fetch_pkg::INSTR_W-1:0] out_instr,
  input logic                          out_pred_taken,
  input logic                          res_valid,
  input logic                          res_mispredict
);

  // IF/ID must come out of reset empty
  reset_empty: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else $error("out_valid high while rst_n is low");

  // Held item may not change under back-pressure
  hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> $stable(out_pc) && $stable(out_instr)
                                && $stable(out_pred_taken))
    else $error("IF/ID payload changed while stalled");

  // Flush drops the wrong-path item at the resolve edge
  flush_drop: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid && res_mispredict |=> !out_valid)
    else $error("out_valid still high after a misprediction");

endmodule

bind fetch_top tb_fetch_asserts tb_fetch_asserts_inst (.*);

// File: testbench/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;
  import fetch_pkg::*;

  localparam int TD_WORDS   = 14;
  localparam int PROG_WORDS = 8;
  localparam int SEQ_CYCLES = 24;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               load_en;
  logic [IMEM_AW-1:0] load_addr;
  logic [INSTR_W-1:0] load_data;
  logic               out_valid;
  logic               out_ready;
  logic [ADDR_W-1:0]  out_pc;
  logic [INSTR_W-1:0] out_instr;
  logic               out_pred_taken;
  logic               res_valid;
  logic [ADDR_W-1:0]  res_pc;
  logic               res_taken;
  logic [ADDR_W-1:0]  res_target;
  logic               res_mispredict;

  logic [15:0]        td [TD_WORDS];      // Data file contents
  logic [INSTR_W-1:0] prog [IMEM_DEPTH];  // What was loaded
  int                 ctr [BP_ENTRIES];   // Model counters 0 to 3
  logic [ADDR_W-1:0]  btb [BP_ENTRIES];
  logic               btb_v [BP_ENTRIES];
  logic [ADDR_W-1:0]  exp_pc;              // Next PC decode should see
  logic [ADDR_W-1:0]  last_pc;
  logic [ADDR_W-1:0]  watch_pc;
  logic [ADDR_W-1:0]  watch_next;
  logic               watch_pred;
  int                 watch_state;         // 0 looking, 1 seen, 2 follower seen
  logic [31:0]        rng = 32'd49333;
  int                 errors = 0;
  int                 test_start = 0;
  int                 n_tests = 0;
  int                 n_accepted = 0;

  fetch_top fetch_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .load_en        (load_en),
    .load_addr      (load_addr),
    .load_data      (load_data),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_pc         (out_pc),
    .out_instr      (out_instr),
    .out_pred_taken (out_pred_taken),
    .res_valid      (res_valid),
    .res_pc         (res_pc),
    .res_taken      (res_taken),
    .res_target     (res_target),
    .res_mispredict (res_mispredict)
  );

  always #2 clk = ~clk;  // 4 ns period

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Background program where every bit of the word address matters
  function automatic logic [15:0] fill_word(input int i);
    logic [15:0] a;
    a = 16'(i);
    return (a * 16'h9E37) ^ 16'h5AA5;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // Predictor model
  //////////////////////////////////////////////////////////////////////////
  function automatic logic model_pred(input logic [ADDR_W-1:0] pc);
    return (ctr[pc[3:0]] >= 2) && btb_v[pc[3:0]];  // Taken state and known target
  endfunction

  task automatic model_update(input logic [ADDR_W-1:0] pc, input logic taken,
                              input logic [ADDR_W-1:0] tgt);
    if (taken) begin
      if (ctr[pc[3:0]] < 3) ctr[pc[3:0]]++;
      btb[pc[3:0]]   = tgt;
      btb_v[pc[3:0]] = 1'b1;
    end else if (ctr[pc[3:0]] > 0) begin
      ctr[pc[3:0]]--;
    end
  endtask

  task automatic model_reset();
    for (int i = 0; i < BP_ENTRIES; i++) begin
      ctr[i]   = 1;                             // weak_not_taken
      btb_v[i] = 1'b0;
    end
    exp_pc = RESET_PC;
  endtask

  // Item leaving IF/ID at the coming edge
  task automatic check_item();
    logic exp_pred;
    exp_pred = model_pred(exp_pc);
    assert (out_pc === exp_pc) else begin
      $display("mismatch at %0t: out_pc %h, expected %h", $time, out_pc, exp_pc);
      errors++;
    end
    assert (out_instr === prog[exp_pc[IMEM_AW:1]]) else begin
      $display("mismatch at %0t: out_instr %h at pc %h, expected %h", $time,
               out_instr, exp_pc, prog[exp_pc[IMEM_AW:1]]);
      errors++;
    end
    assert (out_pred_taken === exp_pred) else begin
      $display("mismatch at %0t: out_pred_taken %b at pc %h, expected %b", $time,
               out_pred_taken, exp_pc, exp_pred);
      errors++;
    end
    if (watch_state == 1) begin
      watch_next  = out_pc;
      watch_state = 2;
    end else if (watch_state == 0 && out_pc == watch_pc) begin
      watch_pred  = out_pred_taken;
      watch_state = 1;
    end
    last_pc = out_pc;
    exp_pc  = exp_pred ? btb[exp_pc[3:0]] : exp_pc + 16'd2;
    n_accepted++;
  endtask

  // One clock with outputs read 1 ns after the edge and inputs set for the next one
  task automatic cycle(input logic rdy, input logic rv, input logic rtk,
                       input logic rmis, input logic [15:0] rpc, input logic [15:0] rtgt);
    @(posedge clk);
    #1;
    if (out_valid && rdy) check_item();
    out_ready      = rdy;
    res_valid      = rv;
    res_taken      = rtk;
    res_mispredict = rmis;
    res_pc         = rpc;
    res_target     = rtgt;
    if (rv) begin
      model_update(rpc, rtk, rtgt);
      if (rmis) exp_pc = rtk ? rtgt : rpc + 16'd2;  // Redirect restarts the stream
    end
  endtask

  task automatic run(input int n, input logic rand_ready);
    for (int i = 0; i < n; i++) begin
      rng = xorshift(rng);
      cycle(rand_ready ? (rng[1:0] != 2'b00) : 1'b1, 1'b0, 1'b0, 1'b0, 16'h0, 16'h0);
    end
  endtask

  // Next transfer must come exactly exp_wait cycles from now
  task automatic wait_accept(input int limit, input int exp_wait);
    int start;
    int t;
    start = n_accepted;
    for (t = 0; t < limit && n_accepted == start; t++) begin
      cycle(1'b1, 1'b0, 1'b0, 1'b0, 16'h0, 16'h0);
    end
    if (n_accepted == start) begin
      $display("timeout at %0t: no item accepted from fetch", $time);
      errors++;
    end else begin
      assert (t == exp_wait) else begin
        $display("mismatch at %0t: item accepted after %0d cycles, expected %0d",
                 $time, t, exp_wait);
        errors++;
      end
    end
  endtask

  task automatic wait_watch(input logic [ADDR_W-1:0] pc, input int limit);
    int t;
    watch_pc    = pc;
    watch_state = 0;
    for (t = 0; t < limit && watch_state != 2; t++) run(1, 1'b1);
    if (watch_state != 2) begin
      $display("timeout at %0t: pc %h never fetched with a follower", $time, pc);
      errors++;
    end
  endtask

  // Freeze fetch so resolves do not race in-flight predictions
  task automatic stall_until_valid(input int limit);
    int t;
    for (t = 0; t < limit && !out_valid; t++) begin
      cycle(1'b0, 1'b0, 1'b0, 1'b0, 16'h0, 16'h0);
    end
    cycle(1'b0, 1'b0, 1'b0, 1'b0, 16'h0, 16'h0);
    if (!out_valid) begin
      $display("timeout at %0t: out_valid never rose for the stall", $time);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    n_tests++;
    if (errors == test_start) begin
      $display("test %0d %s: ok", n_tests, name);
    end else begin
      $display("test %0d %s: failed", n_tests, name);
    end
    test_start = errors;
  endtask

  initial begin
    rst_n = 1'b0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    out_ready = 1'b1;
    res_valid = 1'b0;
    res_pc = '0;
    res_taken = 1'b0;
    res_target = '0;
    res_mispredict = 1'b0;
    watch_pc = '0;
    watch_state = 0;
    $readmemh("testbench/fetch_testdata.hex", td);
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      prog[i] = (i < PROG_WORDS) ? td[i] : fill_word(i);
    end
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;

    // Program load while fetch runs on unknown words
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      @(posedge clk);
      #1;
      load_en   = 1'b1;
      load_addr = IMEM_AW'(i);
      load_data = prog[i];
    end
    @(posedge clk);
    #1 load_en = 1'b0;
    rst_n = 1'b0;
    model_reset();
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;

    // First item is valid one edge after reset release, then one per cycle
    run(SEQ_CYCLES, 1'b0);
    assert (n_accepted == SEQ_CYCLES) else begin
      $display("mismatch at %0t: sequential fetch accepted %0d items, expected %0d",
               $time, n_accepted, SEQ_CYCLES);
      errors++;
    end
    end_test("sequential fetch");

    ////////////////////////////////////////////////////////////////////////
    // Back-pressure with a fixed pattern then random
    ////////////////////////////////////////////////////////////////////////
    for (int i = 0; i < 16; i++) cycle(td[8][i], 1'b0, 1'b0, 1'b0, 16'h0, 16'h0);
    run(40, 1'b1);
    end_test("back-pressure");

    cycle(1'b1, 1'b1, 1'b1, 1'b1, td[9], td[10]);  // Taken mispredict
    wait_accept(10, 2);                            // Flush edge plus one refill cycle
    assert (last_pc === td[10]) else begin
      $display("mismatch at %0t: after taken redirect pc %h, expected %h",
               $time, last_pc, td[10]);
      errors++;
    end
    run(6, 1'b1);
    cycle(1'b1, 1'b1, 1'b0, 1'b1, td[9], 16'h0);   // Not-taken mispredict
    wait_accept(10, 2);
    assert (last_pc === td[9] + 16'd2) else begin
      $display("mismatch at %0t: after not-taken redirect pc %h, expected %h",
               $time, last_pc, td[9] + 16'd2);
      errors++;
    end
    run(10, 1'b1);
    end_test("mispredict redirect");

    stall_until_valid(10);
    cycle(1'b0, 1'b1, 1'b1, 1'b0, td[11], td[12]);
    cycle(1'b0, 1'b1, 1'b1, 1'b0, td[11], td[12]);
    cycle(1'b0, 1'b1, 1'b0, 1'b1, td[13], 16'h0);  // Restart ahead of the branch
    wait_watch(td[11], 60);
    assert (watch_pred === 1'b1 && watch_next === td[12]) else begin
      $display("mismatch at %0t: trained pc %h pred %b next %h, expected taken to %h",
               $time, td[11], watch_pred, watch_next, td[12]);
      errors++;
    end
    run(12, 1'b1);
    end_test("training");

    stall_until_valid(10);
    cycle(1'b0, 1'b1, 1'b0, 1'b0, td[11], 16'h0);
    cycle(1'b0, 1'b1, 1'b0, 1'b0, td[11], 16'h0);
    cycle(1'b0, 1'b1, 1'b0, 1'b1, td[13], 16'h0);
    wait_watch(td[11], 60);
    assert (watch_pred === 1'b0 && watch_next === td[11] + 16'd2) else begin
      $display("mismatch at %0t: demoted pc %h pred %b next %h, expected fall-through",
               $time, td[11], watch_pred, watch_next);
      errors++;
    end
    run(8, 1'b1);
    end_test("demotion");

    $display("%0d tests, %0d items accepted, %0d errors", n_tests, n_accepted, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
